// ==== carrierLoop.f ====
carrierLoopPkg.sv
loopRegs.sv
errorAverager.sv
loopFilter.sv
carrierNco.sv
complexMixer.sv
carrierLoop.sv
carrierLoop_properties.sv
tb_carrierLoop.sv

// ==== carrierLoop.sv ====
// Carrier recovery loop top level: registers, averager, filter, NCO and mixer
`timescale 1ns/1ns

module carrierLoop import carrierLoopPkg::*; #(
    parameter int phaseBits = 32
) (
    input  logic        clk,
    input  logic        reset,
    input  phaseErrT    phaseError,
    input  logic        phaseErrorEn,
    input  iqT          sampleIn,
    input  logic        sampleEn,
    input  logic [3:0]  wr,
    input  logic [3:0]  addr,
    input  logic [31:0] din,
    output logic [31:0] dout,
    output iqT          sampleOut,
    output logic        sampleOutEn
);

    loopCfgT  cfg;
    phaseErrT loopError;
    logic     loopFilterEn;
    freqT     lagAccum;
    freqT     freqWord;
    iqT       carrier;

    // ----------------------------------------
    // Control
    // ----------------------------------------
    loopRegs regs (
        .clk(clk), .reset(reset),
        .wr(wr), .addr(addr), .din(din),
        .lagAccum(lagAccum), .freqWord(freqWord),
        .dout(dout), .cfg(cfg)
    );

    // ----------------------------------------
    // Loop filter path
    // ----------------------------------------
    errorAverager averager (
        .clk(clk), .reset(reset),
        .phaseError(phaseError), .phaseErrorEn(phaseErrorEn), .cfg(cfg),
        .loopError(loopError), .loopFilterEn(loopFilterEn)
    );

    loopFilter filter (
        .clk(clk), .reset(reset),
        .loopError(loopError), .loopFilterEn(loopFilterEn), .cfg(cfg),
        .lagAccum(lagAccum), .freqWord(freqWord)
    );

    // Oscillator and derotator
    carrierNco #(.phaseBits(phaseBits)) nco (
        .clk(clk), .reset(reset),
        .sampleEn(sampleEn), .freqWord(freqWord),
        .carrier(carrier)
    );

    complexMixer mixer (
        .clk(clk), .reset(reset),
        .sampleIn(sampleIn), .sampleEn(sampleEn), .carrier(carrier),
        .sampleOut(sampleOut), .sampleOutEn(sampleOutEn)
    );

endmodule

// ==== carrierLoopPkg.sv ====
// Loop types, configuration struct, register map and quarter-wave cosine table
package carrierLoopPkg;

    // ----------------------------------------
    // Data types
    // ----------------------------------------
    // I or Q sample, 17 fraction bits
    typedef logic signed [17:0] sampleT;
    typedef logic signed [7:0]  phaseErrT;
    // Turns per sample scaled by 2^32
    typedef logic [31:0]        freqT;
    // Filter value, top 32 bits line up with freqT
    typedef logic signed [39:0] accT;

    typedef struct packed {
        sampleT re;
        sampleT im;
    } iqT;

    typedef struct packed {
        logic       invertError;
        logic       zeroError;
        logic       clearAccum;
        logic [1:0] averageSelect;
        logic [4:0] leadExp;
        logic [4:0] lagExp;
        logic [31:0] limit;
        freqT       nominalFreq;
    } loopCfgT;

    // ----------------------------------------
    // Register map
    // ----------------------------------------
    localparam logic [3:0] ADDR_CONTROL  = 4'h0;
    localparam logic [3:0] ADDR_GAINS    = 4'h1;
    localparam logic [3:0] ADDR_LIMIT    = 4'h2;
    localparam logic [3:0] ADDR_NOMINAL  = 4'h3;
    localparam logic [3:0] ADDR_LAGACCUM = 4'h4;
    localparam logic [3:0] ADDR_FREQ     = 4'h5;

    // cos(k * 5.625 deg) * 131071 for k = 0..16
    localparam sampleT cosTable [17] = '{
        18'sd131071, 18'sd130440, 18'sd128553, 18'sd125427,
        18'sd121094, 18'sd115594, 18'sd108982, 18'sd101319,
        18'sd92681,  18'sd83151,  18'sd72819,  18'sd61786,
        18'sd50159,  18'sd38048,  18'sd25571,  18'sd12847,
        18'sd0
    };

endpackage

// ==== carrierLoop_properties.sv ====
// Concurrent assertions on loop strobes and lag integrator saturation
`timescale 1ns/1ns

module carrierLoop_properties (
    input logic        clk,
    input logic        reset,
    input logic        loopFilterEn,
    input logic        sampleEn,
    input logic        sampleOutEn,
    input logic [31:0] lagAccum,
    input logic [31:0] limit
);

    // Filter strobe is a single-cycle pulse
    assert property (@(posedge clk) disable iff (reset)
        loopFilterEn |=> !loopFilterEn)
        else $error("loopFilterEn high in two consecutive cycles");

    // Output strobe three cycles behind the input strobe
    assert property (@(posedge clk) disable iff (reset)
        sampleEn |-> ##3 sampleOutEn)
        else $error("sampleOutEn did not follow sampleEn after 3 cycles");

    // ----------------------------------------
    // Integrator clamp
    // ----------------------------------------
    assert property (@(posedge clk) disable iff (reset)
        ($signed({lagAccum[31], lagAccum}) <= $signed({1'b0, limit}))
        && ($signed({lagAccum[31], lagAccum}) >= -$signed({1'b0, limit})))
        else $error("lag integrator exceeds limit");

endmodule

bind carrierLoop carrierLoop_properties props0 (
    .clk(clk), .reset(reset),
    .loopFilterEn(loopFilterEn), .sampleEn(sampleEn), .sampleOutEn(sampleOutEn),
    .lagAccum(lagAccum), .limit(cfg.limit)
);

// ==== carrierNco.sv ====
// Phase accumulator and quarter-wave cosine/sine lookup for the carrier
`timescale 1ns/1ns

module carrierNco import carrierLoopPkg::*; #(
    parameter int phaseBits = 32
) (
    input  logic clk,
    input  logic reset,
    input  logic sampleEn,
    input  freqT freqWord,
    output iqT   carrier
);

    logic [phaseBits-1:0] phase;
    logic [1:0]           quadrant;
    logic [4:0]           index;
    logic [4:0]           mirror;
    sampleT               cosVal;
    sampleT               negSinVal;

    // ----------------------------------------
    // Phase accumulator
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= '0;
        end else if (sampleEn) begin
            phase <= phase + freqWord[31 -: phaseBits];
        end
    end

    // Top two bits pick the quadrant, next four the table step
    assign quadrant = phase[phaseBits-1 -: 2];
    assign index    = {1'b0, phase[phaseBits-3 -: 4]};
    assign mirror   = 5'd16 - index;

    // ----------------------------------------
    // Quadrant symmetry
    // ----------------------------------------
    // Output is exp(-j*phase) so the mixer derotates
    always_comb begin
        case (quadrant)
            2'd0: begin
                cosVal    = cosTable[index];
                negSinVal = -cosTable[mirror];
            end
            2'd1: begin
                cosVal    = -cosTable[mirror];
                negSinVal = -cosTable[index];
            end
            2'd2: begin
                cosVal    = -cosTable[index];
                negSinVal = cosTable[mirror];
            end
            default: begin
                cosVal    = cosTable[mirror];
                negSinVal = cosTable[index];
            end
        endcase
    end

    // Lookup uses the phase before this sample's advance
    always_ff @(posedge clk) begin
        if (sampleEn) begin
            carrier.re <= cosVal;
            carrier.im <= negSinVal;
        end
    end

endmodule

// ==== complexMixer.sv ====
// Complex multiplier with rounding, saturation and strobe alignment
`timescale 1ns/1ns

module complexMixer import carrierLoopPkg::*; (
    input  logic clk,
    input  logic reset,
    input  iqT   sampleIn,
    input  logic sampleEn,
    input  iqT   carrier,
    output iqT   sampleOut,
    output logic sampleOutEn
);

    iqT                 sampleDly;
    logic signed [36:0] prodRe;
    logic signed [36:0] prodIm;
    logic [2:0]         enPipe;

    // Drop 17 fraction bits, round half up, clamp to 18 bits
    function automatic sampleT roundSat(input logic signed [36:0] prod);
        logic signed [36:0] rounded;
        logic signed [19:0] scaled;
        rounded = prod + 37'sd65536;
        scaled  = rounded[36:17];
        if (scaled > 20'sd131071) begin
            return 18'sd131071;
        end else if (scaled < -20'sd131072) begin
            return -18'sd131072;
        end
        return scaled[17:0];
    endfunction

    // ----------------------------------------
    // Datapath, three register stages
    // ----------------------------------------
    always_ff @(posedge clk) begin
        // Stage 1 lines the sample up with the registered carrier
        sampleDly <= sampleIn;
        // Stage 2
        prodRe <= $signed(sampleDly.re) * $signed(carrier.re)
                - $signed(sampleDly.im) * $signed(carrier.im);
        prodIm <= $signed(sampleDly.re) * $signed(carrier.im)
                + $signed(sampleDly.im) * $signed(carrier.re);
        // Stage 3
        sampleOut.re <= roundSat(prodRe);
        sampleOut.im <= roundSat(prodIm);
    end

    // Strobe rides alongside the data
    always_ff @(posedge clk) begin
        if (reset) begin
            enPipe <= '0;
        end else begin
            enPipe <= {enPipe[1:0], sampleEn};
        end
    end

    assign sampleOutEn = enPipe[2];

endmodule

// ==== errorAverager.sv ====
// Phase error conditioning and power-of-two block averaging
`timescale 1ns/1ns

module errorAverager import carrierLoopPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  phaseErrT phaseError,
    input  logic     phaseErrorEn,
    input  loopCfgT  cfg,
    output phaseErrT loopError,
    output logic     loopFilterEn
);

    phaseErrT           condError;
    logic signed [15:0] shiftError;
    logic signed [15:0] errorAcc;
    logic signed [15:0] blockSum;
    logic [2:0]         strobeCount;
    logic [2:0]         lastCount;
    logic               terminalCount;

    // Invert saturates so -128 becomes +127
    always_comb begin
        if (cfg.zeroError) begin
            condError = '0;
        end else if (cfg.invertError) begin
            condError = (phaseError == 8'sh80) ? 8'sh7f : -phaseError;
        end else begin
            condError = phaseError;
        end
    end

    // Pre-divide by the block length so the sum lands in the top byte
    assign shiftError = 16'(condError) << (4'd8 - {2'b00, cfg.averageSelect});
    assign blockSum   = errorAcc + shiftError;

    assign lastCount     = 3'((4'd1 << cfg.averageSelect) - 4'd1);
    assign terminalCount = (strobeCount >= lastCount);

    // ----------------------------------------
    // Block counter and accumulator
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            strobeCount  <= '0;
            errorAcc     <= '0;
            loopFilterEn <= 1'b0;
        end else begin
            loopFilterEn <= phaseErrorEn && terminalCount;
            if (phaseErrorEn) begin
                if (terminalCount) begin
                    strobeCount <= '0;
                    errorAcc    <= '0;
                end else begin
                    strobeCount <= strobeCount + 3'd1;
                    errorAcc    <= blockSum;
                end
            end
        end
    end

    // Rounded mean, completing strobe included
    always_ff @(posedge clk) begin
        if (phaseErrorEn && terminalCount) begin
            loopError <= blockSum[15:8] + {7'd0, blockSum[7]};
        end
    end

endmodule

// ==== loopFilter.sv ====
// Lead/lag loop filter with saturating lag integrator and frequency word register
`timescale 1ns/1ns

module loopFilter import carrierLoopPkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  phaseErrT loopError,
    input  logic     loopFilterEn,
    input  loopCfgT  cfg,
    output freqT     lagAccum,
    output freqT     freqWord
);

    logic [5:0]         leadShift;
    logic [5:0]         lagShift;
    accT                leadError;
    logic signed [47:0] lagStep;
    logic signed [47:0] lagSum;
    logic signed [39:0] lagTop;
    logic signed [39:0] limitTop;
    accT                lagReg;
    accT                lagNext;
    accT                filterSum;

    // Extra 8 bits of headroom below the frequency word
    assign leadShift = {1'b0, cfg.leadExp} + 6'd8;
    assign lagShift  = {1'b0, cfg.lagExp} + 6'd8;

    // ----------------------------------------
    // Lead path
    // ----------------------------------------
    assign leadError = accT'(loopError) << leadShift;

    // ----------------------------------------
    // Lag path
    // ----------------------------------------
    // Wide enough that the largest step cannot wrap before the clamp
    assign lagStep  = 48'(loopError) << lagShift;
    assign lagSum   = 48'(lagReg) + lagStep;
    assign lagTop   = lagSum[47:8];
    assign limitTop = {8'h00, cfg.limit};

    always_comb begin
        if (cfg.clearAccum) begin
            lagNext = '0;
        end else if (lagTop > limitTop) begin
            lagNext = {cfg.limit, 8'h00};
        end else if (lagTop < -limitTop) begin
            lagNext = {-cfg.limit, 8'h00};
        end else begin
            lagNext = lagSum[39:0];
        end
    end

    assign filterSum = leadError + lagNext;

    always_ff @(posedge clk) begin
        if (reset) begin
            lagReg <= '0;
        end else if (cfg.clearAccum || loopFilterEn) begin
            lagReg <= lagNext;
        end
    end

    // New word one cycle after the filter strobe, held in between
    always_ff @(posedge clk) begin
        if (reset) begin
            freqWord <= '0;
        end else if (loopFilterEn) begin
            freqWord <= filterSum[39:8] + cfg.nominalFreq;
        end
    end

    assign lagAccum = lagReg[39:8];

endmodule

// ==== loopRegs.sv ====
// Loop control registers with byte-lane writes and read-back multiplexer
`timescale 1ns/1ns

module loopRegs import carrierLoopPkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic [3:0]  wr,
    input  logic [3:0]  addr,
    input  logic [31:0] din,
    input  freqT        lagAccum,
    input  freqT        freqWord,
    output logic [31:0] dout,
    output loopCfgT     cfg
);

    // Words 0..3 are writable, 4 and 5 are live status
    logic [31:0] regFile [4];
    logic        writable;

    assign writable = (addr[3:2] == 2'b00);

    // ----------------------------------------
    // Write side
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            regFile[ADDR_CONTROL[1:0]] <= '0;
            regFile[ADDR_GAINS[1:0]]   <= '0;
            // Widest clamp until software narrows it
            regFile[ADDR_LIMIT[1:0]]   <= 32'h7fff_ffff;
            regFile[ADDR_NOMINAL[1:0]] <= '0;
        end else if (writable) begin
            for (int lane = 0; lane < 4; lane++) begin
                if (wr[lane]) begin
                    regFile[addr[1:0]][8*lane +: 8] <= din[8*lane +: 8];
                end
            end
        end
    end

    // ----------------------------------------
    // Field decode
    // ----------------------------------------
    // Control: bit 0 invert, bit 1 zero, bit 2 clear, bits 5:4 average select
    // Gains: bits 4:0 lead exponent, bits 12:8 lag exponent
    always_comb begin
        cfg.invertError   = regFile[ADDR_CONTROL[1:0]][0];
        cfg.zeroError     = regFile[ADDR_CONTROL[1:0]][1];
        cfg.clearAccum    = regFile[ADDR_CONTROL[1:0]][2];
        cfg.averageSelect = regFile[ADDR_CONTROL[1:0]][5:4];
        cfg.leadExp       = regFile[ADDR_GAINS[1:0]][4:0];
        cfg.lagExp        = regFile[ADDR_GAINS[1:0]][12:8];
        cfg.limit         = regFile[ADDR_LIMIT[1:0]];
        cfg.nominalFreq   = regFile[ADDR_NOMINAL[1:0]];
    end

    // Read mux
    always_comb begin
        case (addr)
            ADDR_CONTROL,
            ADDR_GAINS,
            ADDR_LIMIT,
            ADDR_NOMINAL:  dout = regFile[addr[1:0]];
            ADDR_LAGACCUM: dout = lagAccum;
            ADDR_FREQ:     dout = freqWord;
            default:       dout = '0;
        endcase
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# Build and run the carrier loop testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wall -Wno-fatal \
    -f carrierLoop.f --top-module tb_carrierLoop -o simv \
    && ./obj_dir/simv > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "Everything OK" sim.log && echo "Simulation passed" && exit 0 \
    || { echo "Simulation failed"; exit 1; }

// ==== tb_carrierLoop.sv ====
// Carrier loop testbench with register, averaging, clamp and mixer checks
`timescale 1ns/1ns

module tb_carrierLoop import carrierLoopPkg::*; ();

    typedef struct packed {
        logic [31:0] control;
        logic [31:0] gains;
        logic [31:0] limit;
        logic [31:0] nominal;
        logic [63:0] errs;
    } rowT;

    logic        clk;
    logic        reset;
    phaseErrT    phaseError;
    logic        phaseErrorEn;
    iqT          sampleIn;
    logic        sampleEn;
    logic [3:0]  wr;
    logic [3:0]  addr;
    logic [31:0] din;
    logic [31:0] dout;
    iqT          sampleOut;
    logic        sampleOutEn;

    rowT         rows [6];
    int          seed = 32'hb01bd159;

    carrierLoop #(.phaseBits(32)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ----------------------------------------
    // Reporting
    // ----------------------------------------
    task automatic stopRun(input string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string what, input logic [63:0] got,
                              input logic [63:0] expected);
        if (got !== expected) begin
            $display("ERROR at %0t ns: %s got %h expected %h", $time, what, got, expected);
            stopRun("value mismatch");
        end
    endtask

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    function automatic int condError(input int e, input logic [31:0] ctrl);
        if (ctrl[1]) return 0;
        if (ctrl[0]) return (e == -128) ? 127 : -e;
        return e;
    endfunction

    // Rounded mean of 2^sel conditioned errors
    function automatic int blockMean(input logic [63:0] errs, input logic [31:0] ctrl);
        int sum;
        int sel;
        sum = 0;
        sel = int'(ctrl[5:4]);
        for (int i = 0; i < (1 << sel); i++) begin
            sum += condError(int'($signed(errs[8*i +: 8])), ctrl) * (1 << (8 - sel));
        end
        return (sum + 128) >>> 8;
    endfunction

    function automatic longint nextLag(input longint lag, input int err,
                                       input int lagExp, input longint limit);
        longint t;
        t = lag + (longint'(err) <<< lagExp);
        if (t > limit) return limit;
        if (t < -limit) return -limit;
        return t;
    endfunction

    function automatic logic [31:0] expectFreq(input int err, input int leadExp,
                                               input longint lag, input logic [31:0] nominal);
        longint f;
        f = (longint'(err) <<< leadExp) + lag + longint'(nominal);
        return f[31:0];
    endfunction

    function automatic sampleT scaleRound(input longint p);
        longint r;
        r = (p + 65536) >>> 17;
        if (r > 131071) r = 131071;
        if (r < -131072) r = -131072;
        return r[17:0];
    endfunction

    // ----------------------------------------
    // Bus and strobe drivers
    // ----------------------------------------
    task automatic writeReg(input logic [3:0] a, input logic [31:0] d, input logic [3:0] lanes);
        @(posedge clk);
        #1;
        wr = lanes;
        addr = a;
        din = d;
        @(posedge clk);
        #1;
        wr = 4'h0;
    endtask

    task automatic readReg(input logic [3:0] a, output logic [31:0] d);
        @(posedge clk);
        #1;
        addr = a;
        #1;
        d = dout;
    endtask

    task automatic driveErrors(input logic [63:0] errs, input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            #1;
            phaseError = errs[8*i +: 8];
            phaseErrorEn = 1'b1;
        end
        @(posedge clk);
        #1;
        phaseErrorEn = 1'b0;
    endtask

    // Returns one cycle after the filter strobe once freqWord is fresh
    task automatic waitFilter();
        bit found;
        found = 0;
        for (int n = 0; n < 10 && !found; n++) begin
            if (dut0.loopFilterEn) begin
                found = 1;
            end else begin
                @(posedge clk);
                #1;
            end
        end
        if (!found) stopRun("Timeout: loopFilterEn never went high");
        @(posedge clk);
        #1;
    endtask

    task automatic sendSample(input iqT s, output iqT result, output int latency);
        bit found;
        found = 0;
        latency = 0;
        @(posedge clk);
        #1;
        sampleIn = s;
        sampleEn = 1'b1;
        for (int n = 1; n <= 10 && !found; n++) begin
            @(posedge clk);
            #1;
            sampleEn = 1'b0;
            if (sampleOutEn) begin
                found = 1;
                latency = n;
                result = sampleOut;
            end
        end
        if (!found) stopRun("Timeout: sampleOutEn never went high");
    endtask

    task automatic loadTable();
        rows[0] = '{32'h00, 32'h0102, 32'h7fffffff, 32'h1000, 64'h0a};
        rows[1] = '{32'h10, 32'h0003, 32'h7fffffff, 32'h0, 64'hfd05};
        rows[2] = '{32'h20, 32'h0201, 32'h7fffffff, 32'h0, 64'h806403f9};
        rows[3] = '{32'h30, 32'h0404, 32'd20, 32'h0, 64'hf707060504030201};
        rows[4] = '{32'h21, 32'h0102, 32'h7fffffff, 32'h200, 64'h09fb1480};
        rows[5] = '{32'h12, 32'h0101, 32'h7fffffff, 32'h12345678, 64'h3c32};
    endtask

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        logic [31:0] rd;
        int          mean;
        longint      lag;
        iqT          s;
        iqT          result;
        int          latency;
        sampleT      cr [4];
        sampleT      ci [4];

        reset = 1'b1;
        phaseError = '0;
        phaseErrorEn = 1'b0;
        sampleIn = '0;
        sampleEn = 1'b0;
        wr = 4'h0;
        addr = 4'h0;
        din = '0;
        loadTable();
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;

        // Register read-back with byte lanes
        readReg(ADDR_LIMIT, rd);
        checkValue("limit after reset", rd, 32'h7fffffff);
        readReg(ADDR_FREQ, rd);
        checkValue("freqWord after reset", rd, 32'h0);
        writeReg(ADDR_CONTROL, 32'h33, 4'hf);
        readReg(ADDR_CONTROL, rd);
        checkValue("control", rd, 32'h33);
        writeReg(ADDR_GAINS, 32'h0a05, 4'hf);
        readReg(ADDR_GAINS, rd);
        checkValue("gains", rd, 32'h0a05);
        writeReg(ADDR_LIMIT, 32'h00012345, 4'hf);
        writeReg(ADDR_LIMIT, 32'h00009900, 4'b0010);
        readReg(ADDR_LIMIT, rd);
        checkValue("limit partial write", rd, 32'h00019945);
        writeReg(ADDR_NOMINAL, 32'h12345678, 4'hf);
        writeReg(ADDR_NOMINAL, 32'hffaaccee, 4'b0100);
        readReg(ADDR_NOMINAL, rd);
        checkValue("nominal partial write", rd, 32'h12aa5678);

        // Table rows with the integrator cleared before each
        foreach (rows[r]) begin
            writeReg(ADDR_CONTROL, 32'h4, 4'hf);
            writeReg(ADDR_GAINS, rows[r].gains, 4'hf);
            writeReg(ADDR_LIMIT, rows[r].limit, 4'hf);
            writeReg(ADDR_NOMINAL, rows[r].nominal, 4'hf);
            writeReg(ADDR_CONTROL, rows[r].control, 4'hf);
            driveErrors(rows[r].errs, 1 << rows[r].control[5:4]);
            waitFilter();
            mean = blockMean(rows[r].errs, rows[r].control);
            lag = nextLag(0, mean, int'(rows[r].gains[12:8]), longint'(rows[r].limit));
            readReg(ADDR_LAGACCUM, rd);
            checkValue($sformatf("row %0d lagAccum", r), rd, lag[31:0]);
            readReg(ADDR_FREQ, rd);
            checkValue($sformatf("row %0d freqWord", r), rd,
                       expectFreq(mean, int'(rows[r].gains[4:0]), lag, rows[r].nominal));
        end

        // Saturation at plus and minus limit
        writeReg(ADDR_CONTROL, 32'h4, 4'hf);
        writeReg(ADDR_GAINS, 32'h0400, 4'hf);
        writeReg(ADDR_LIMIT, 32'd1000, 4'hf);
        writeReg(ADDR_NOMINAL, 32'h0, 4'hf);
        writeReg(ADDR_CONTROL, 32'h0, 4'hf);
        lag = 0;
        for (int i = 0; i < 6; i++) begin
            driveErrors((i < 3) ? 64'd100 : 64'h9c, 1);
            waitFilter();
            lag = nextLag(lag, (i < 3) ? 100 : -100, 4, 1000);
            readReg(ADDR_LAGACCUM, rd);
            checkValue("clamped lagAccum", rd, lag[31:0]);
        end
        checkValue("negative clamp", rd, 32'hfffffc18);
        writeReg(ADDR_CONTROL, 32'h4, 4'hf);
        readReg(ADDR_LAGACCUM, rd);
        checkValue("lagAccum after clear", rd, 32'h0);

        // Zero frequency gives a carrier of 131071 + j0
        writeReg(ADDR_CONTROL, 32'h6, 4'hf);
        driveErrors(64'h0, 1);
        waitFilter();
        readReg(ADDR_FREQ, rd);
        checkValue("freqWord zero", rd, 32'h0);
        for (int i = 0; i < 4; i++) begin
            s.re = 18'($random(seed));
            s.im = 18'($random(seed));
            sendSample(s, result, latency);
            checkValue("mixer latency", latency, 3);
            checkValue("unrotated re", result.re, scaleRound(longint'(s.re) * 131071));
            checkValue("unrotated im", result.im, scaleRound(longint'(s.im) * 131071));
        end

        // Quarter-turn steps rotate by exp(-j*k*90deg)
        writeReg(ADDR_NOMINAL, 32'h40000000, 4'hf);
        driveErrors(64'h0, 1);
        waitFilter();
        cr = '{cosTable[0], cosTable[16], -cosTable[0], cosTable[16]};
        ci = '{cosTable[16], -cosTable[0], cosTable[16], cosTable[0]};
        for (int k = 0; k < 4; k++) begin
            s.re = 18'($random(seed));
            s.im = 18'($random(seed));
            sendSample(s, result, latency);
            checkValue("rotated latency", latency, 3);
            checkValue($sformatf("rotated re k=%0d", k), result.re,
                       scaleRound(longint'(s.re) * cr[k] - longint'(s.im) * ci[k]));
            checkValue($sformatf("rotated im k=%0d", k), result.im,
                       scaleRound(longint'(s.re) * ci[k] + longint'(s.im) * cr[k]));
        end

        $display("Everything OK");
        $finish;
    end

endmodule
